//--- legv8_pipe.f
+incdir+verilog
verilog/legv8_pkg.sv
verilog/legv8_fetch.sv
verilog/legv8_decode.sv
verilog/legv8_regfile.sv
verilog/legv8_execute.sv
verilog/legv8_mem_wb.sv
verilog/legv8_core.sv
tb/legv8_core_sva.sv
tb/legv8_core_tb.sv

//--- tb/legv8_core_tb.sv
`include "legv8_config.svh"

module legv8_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          IMEM_WORDS = 64;
  localparam logic [4:0]  XZR        = `LEGV8_ZERO_REG;
  localparam logic [31:0] SEED       = 32'h853f_af2c;
  // Reset plus twice (length + 8) for each test of lengths 8, 12, 6, 7, 9 and 10 x 20
  localparam int CYCLE_LIMIT = 10 + 2 * ((8 + 8) + (12 + 8) + (6 + 8) + (7 + 8) + (9 + 8)
                                         + 10 * (20 + 8));

  typedef struct packed {
    legv8_pkg::xlen_t addr;
    legv8_pkg::xlen_t data;
  } store_t;
  typedef store_t store_q_t[$];

  logic               CLOCK;
  logic               arst_n;
  legv8_pkg::instr_t  instr;
  legv8_pkg::xlen_t   mem_rdata;
  legv8_pkg::xlen_t   pc;
  legv8_pkg::xlen_t   mem_addr;
  legv8_pkg::xlen_t   mem_wdata;
  logic               mem_read;
  logic               mem_write;

  legv8_pkg::instr_t  imem [IMEM_WORDS];
  legv8_pkg::xlen_t   dmem [32];
  legv8_pkg::instr_t  prog [$];          // Program of the current test
  store_q_t           expected;
  store_t             next_store;
  string              test_name;
  int                 cycle_count = 0;

  legv8_core uut (
    .CLOCK(CLOCK), .arst_n(arst_n), .instr(instr), .mem_rdata(mem_rdata),
    .pc(pc), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_read(mem_read), .mem_write(mem_write)
  );

  initial begin
    CLOCK = 1'b0;
    forever #2 CLOCK = ~CLOCK;
  end

  // Zero-wait-state memories
  assign instr     = (pc < IMEM_WORDS * 4) ? imem[pc[7:2]] : '0;
  assign mem_rdata = dmem[mem_addr[4:0]];

  always @(posedge CLOCK) begin
    if (mem_write) dmem[mem_addr[4:0]] <= mem_wdata;
  end

  function automatic legv8_pkg::instr_t r_type(input logic [10:0] opc,
                                               input logic [4:0] rd, rn, rm);
    return {opc, rm, 6'b0, rn, rd};
  endfunction

  function automatic legv8_pkg::instr_t i_type(input logic [9:0] pre, input logic [4:0] rd, rn,
                                               input logic [11:0] imm);
    return {pre, imm, rn, rd};
  endfunction

  function automatic legv8_pkg::instr_t d_type(input logic [10:0] opc, input logic [4:0] rt, rn,
                                               input logic [8:0] off);
    return {opc, off, 2'b00, rn, rt};
  endfunction

  // Sequential ISA model that returns every store in program order
  function automatic store_q_t run_reference(input int n);
    legv8_pkg::xlen_t   x [32];
    legv8_pkg::xlen_t   mem [32];
    store_q_t           stores;
    legv8_pkg::instr_t  ins;
    legv8_pkg::opcode_t opc;
    legv8_pkg::xlen_t   a, b, t, imm12, addr, res;
    logic               wr;
    for (int i = 0; i < 32; i++) begin
      x[i]   = i;
      mem[i] = i * 5;
    end
    x[31] = '0;                          // XZR, never written below
    for (int k = 0; k < n; k++) begin
      ins   = imem[k];
      opc   = ins[31:21];
      a     = x[ins[9:5]];
      b     = x[ins[20:16]];
      t     = x[ins[4:0]];
      imm12 = {52'b0, ins[21:10]};
      addr  = a + {{55{ins[20]}}, ins[20:12]};
      wr    = 1'b1;
      res   = '0;
      case (opc)
        legv8_pkg::OPC_ADD:  res = a + b;
        legv8_pkg::OPC_SUB:  res = a - b;
        legv8_pkg::OPC_AND:  res = a & b;
        legv8_pkg::OPC_ORR:  res = a | b;
        legv8_pkg::OPC_EOR:  res = a ^ b;
        legv8_pkg::OPC_LDUR: res = mem[addr[4:0]];
        legv8_pkg::OPC_STUR: begin
          wr             = 1'b0;
          mem[addr[4:0]] = t;
          stores.push_back({addr, t});
        end
        default: begin
          case (opc[10:1])
            legv8_pkg::OPC_ADDI: res = a + imm12;
            legv8_pkg::OPC_SUBI: res = a - imm12;
            legv8_pkg::OPC_ANDI: res = a & imm12;
            legv8_pkg::OPC_ORRI: res = a | imm12;
            legv8_pkg::OPC_EORI: res = a ^ imm12;
            default:             wr = 1'b0;   // Not a kept instruction
          endcase
        end
      endcase
      if (wr && ins[4:0] != XZR) x[ins[4:0]] = res;
    end
    return stores;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_mismatch(input string what, input legv8_pkg::xlen_t exp,
                                 input legv8_pkg::xlen_t act);
    abort_run($sformatf("ERROR test %s %s expected %h actual %h", test_name, what, exp, act));
  endtask

  task automatic check_store_addr(input legv8_pkg::xlen_t exp, input legv8_pkg::xlen_t act);
    if (act !== exp) report_mismatch("store address", exp, act);
  endtask

  task automatic check_store_data(input legv8_pkg::xlen_t exp, input legv8_pkg::xlen_t act);
    if (act !== exp) report_mismatch("store data", exp, act);
  endtask

  task automatic check_pc(input legv8_pkg::xlen_t exp, input legv8_pkg::xlen_t act);
    if (act !== exp) report_mismatch("pc", exp, act);
  endtask

  // Compare each store against the next one the model expects
  always @(negedge CLOCK) begin
    if (arst_n && mem_write) begin
      if (expected.size() == 0) begin
        abort_run($sformatf("Test %s wrote memory at address %h when no store was expected",
                            test_name, mem_addr));
      end else begin
        next_store = expected.pop_front();
        check_store_addr(next_store.addr, mem_addr);
        check_store_data(next_store.data, mem_wdata);
      end
    end
  end

  always @(posedge CLOCK) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      abort_run($sformatf("Timeout in test %s after %0d cycles", test_name, cycle_count));
    end
  end

  task automatic load_memories(input int n);
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = (i < n) ? prog[i] : '0;  // Zero past the end is a bubble
    end
    for (int i = 0; i < 32; i++) begin
      dmem[i] = legv8_pkg::xlen_t'(i * 5);
    end
  endtask

  // hold_cycle is the cycle in which pc repeats its value or -1 for none
  task automatic run_program(input string name, input bit track_pc, input int hold_cycle);
    int               n;
    int               cycle;
    legv8_pkg::xlen_t exp_pc;
    n         = prog.size();
    test_name = name;
    @(posedge CLOCK);
    arst_n <= 1'b0;
    @(negedge CLOCK);
    load_memories(n);
    expected = run_reference(n);
    repeat (10) @(posedge CLOCK);
    arst_n <= 1'b1;
    @(negedge CLOCK);
    if (mem_read || mem_write) abort_run($sformatf("Memory strobe high after reset in %s", name));
    check_pc('0, pc);
    cycle = 0;
    while (pc < legv8_pkg::xlen_t'(4 * (n + 5))) begin
      if (track_pc) begin
        exp_pc = 4 * ((hold_cycle >= 0 && cycle >= hold_cycle) ? cycle - 1 : cycle);
        check_pc(exp_pc, pc);
      end
      @(negedge CLOCK);
      cycle++;
    end
    @(posedge CLOCK);
    if (expected.size() != 0) begin
      abort_run($sformatf("Test %s drained with %0d expected stores never written",
                          name, expected.size()));
    end
  endtask

  function automatic logic [4:0] pick_reg();
    int r;
    r = $urandom_range(0, 8);
    return (r == 8) ? XZR : 5'(r);
  endfunction

  function automatic logic [4:0] pick_base();
    return ($urandom_range(0, 1) != 0) ? XZR : pick_reg();
  endfunction

  task automatic build_random_program(input int len);
    logic [10:0] r_ops [5];
    logic [9:0]  i_ops [5];
    int          kind;
    r_ops = '{legv8_pkg::OPC_ADD, legv8_pkg::OPC_SUB, legv8_pkg::OPC_AND,
              legv8_pkg::OPC_ORR, legv8_pkg::OPC_EOR};
    i_ops = '{legv8_pkg::OPC_ADDI, legv8_pkg::OPC_SUBI, legv8_pkg::OPC_ANDI,
              legv8_pkg::OPC_ORRI, legv8_pkg::OPC_EORI};
    prog = {};
    for (int i = 0; i < len; i++) begin
      kind = $urandom_range(0, 13);
      if (kind < 5) begin
        prog.push_back(r_type(r_ops[kind], pick_reg(), pick_reg(), pick_reg()));
      end else if (kind < 10) begin
        prog.push_back(i_type(i_ops[kind-5], pick_reg(), pick_reg(), 12'($urandom)));
      end else begin
        prog.push_back(d_type((kind < 12) ? legv8_pkg::OPC_LDUR : legv8_pkg::OPC_STUR,
                              pick_reg(), pick_base(), 9'($urandom_range(0, 31))));
      end
    end
  endtask

  initial begin
    void'($urandom(SEED));
    arst_n = 1'b0;
    load_memories(0);

    prog = {i_type(legv8_pkg::OPC_ADDI, 1, 2, 5),
            r_type(legv8_pkg::OPC_ADD, 3, 1, 4),
            i_type(legv8_pkg::OPC_SUBI, 5, 3, 1),
            d_type(legv8_pkg::OPC_STUR, 5, XZR, 2),
            r_type(legv8_pkg::OPC_EOR, 6, 5, 3),
            i_type(legv8_pkg::OPC_ORRI, 7, 6, 12'h040),
            d_type(legv8_pkg::OPC_STUR, 7, 6, 3),
            i_type(legv8_pkg::OPC_ANDI, 2, 7, 12'h00f)};
    run_program("pc_step_no_loads", 1'b1, -1);

    prog = {i_type(legv8_pkg::OPC_ADDI, 1, XZR, 100),
            r_type(legv8_pkg::OPC_ADD, 2, 1, 1),        // EX/MEM forward
            r_type(legv8_pkg::OPC_SUB, 3, 2, 1),        // Both stages forward
            d_type(legv8_pkg::OPC_STUR, 3, XZR, 1),
            i_type(legv8_pkg::OPC_ANDI, 4, 3, 12'h0f0),
            r_type(legv8_pkg::OPC_ORR, 4, 4, 2),
            i_type(legv8_pkg::OPC_EORI, 6, 4, 12'h03c), // Newer EX/MEM beats MEM/WB
            d_type(legv8_pkg::OPC_STUR, 6, XZR, 2),
            r_type(legv8_pkg::OPC_EOR, 7, 6, 3),
            d_type(legv8_pkg::OPC_STUR, 7, 4, 9'h1fd),  // Offset -3
            r_type(legv8_pkg::OPC_ADD, 1, 7, 7),
            d_type(legv8_pkg::OPC_STUR, 1, XZR, 5)};
    run_program("forwarding_chain", 1'b1, -1);

    prog = {d_type(legv8_pkg::OPC_LDUR, 1, 2, 3),
            r_type(legv8_pkg::OPC_ADD, 3, 1, 4),        // Load-use costs one bubble
            d_type(legv8_pkg::OPC_STUR, 3, XZR, 7),
            i_type(legv8_pkg::OPC_ADDI, 5, 3, 1),
            d_type(legv8_pkg::OPC_STUR, 5, XZR, 8),
            r_type(legv8_pkg::OPC_ORR, 6, 1, XZR)};
    run_program("load_use_stall", 1'b1, 3);

    prog = {i_type(legv8_pkg::OPC_ADDI, 5, 3, 12'h123),
            d_type(legv8_pkg::OPC_STUR, 5, XZR, 9),
            i_type(legv8_pkg::OPC_ADDI, 1, 1, 1),
            i_type(legv8_pkg::OPC_ADDI, 2, 2, 2),
            d_type(legv8_pkg::OPC_LDUR, 6, XZR, 9),
            i_type(legv8_pkg::OPC_ADDI, 7, 7, 0),
            d_type(legv8_pkg::OPC_STUR, 6, XZR, 10)};
    run_program("store_then_load", 1'b1, -1);

    prog = {i_type(legv8_pkg::OPC_ADDI, XZR, 1, 7),
            r_type(legv8_pkg::OPC_ADD, 2, XZR, XZR),
            d_type(legv8_pkg::OPC_STUR, 2, XZR, 3),
            r_type(legv8_pkg::OPC_ORR, 3, XZR, 4),
            d_type(legv8_pkg::OPC_STUR, 3, XZR, 4),
            d_type(legv8_pkg::OPC_STUR, XZR, XZR, 5),
            d_type(legv8_pkg::OPC_LDUR, XZR, XZR, 1),   // No stall for XZR target
            r_type(legv8_pkg::OPC_ADD, 4, XZR, 1),
            d_type(legv8_pkg::OPC_STUR, 4, XZR, 6)};
    run_program("zero_register", 1'b1, -1);

    for (int t = 0; t < 10; t++) begin
      build_random_program(20);
      run_program($sformatf("random_%0d", t), 1'b0, -1);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- tb/legv8_core_sva.sv
`include "legv8_config.svh"

module legv8_core_sva (
  input logic              CLOCK,
  input logic              arst_n,
  input logic              stall,
  input logic              mem_read,
  input logic              mem_write,
  input legv8_pkg::xlen_t  pc
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam legv8_pkg::xlen_t PC_STEP = `LEGV8_PC_STEP;

  // One data memory access per cycle
  mem_exclusive: assert property (@(posedge CLOCK) disable iff (!arst_n)
    !(mem_read && mem_write))
    else $error("mem_read and mem_write are high in the same cycle");

  // A load-use bubble costs exactly one cycle
  stall_one_cycle: assert property (@(posedge CLOCK) disable iff (!arst_n)
    stall |=> !stall)
    else $error("stall stayed high for more than one cycle");

  pc_hold_on_stall: assert property (@(posedge CLOCK) disable iff (!arst_n)
    $past(arst_n) |-> (pc == ($past(stall) ? $past(pc) : $past(pc) + PC_STEP)))
    else $error("pc did not follow stall, pc %h", pc);

endmodule

bind legv8_core legv8_core_sva u_sva (
  .CLOCK(CLOCK), .arst_n(arst_n), .stall(stall),
  .mem_read(mem_read), .mem_write(mem_write), .pc(pc)
);

//--- verilog/legv8_core.sv
module legv8_core (
  input  logic               CLOCK,
  input  logic               arst_n,
  input  legv8_pkg::instr_t  instr,
  input  legv8_pkg::xlen_t   mem_rdata,
  output legv8_pkg::xlen_t   pc,
  output legv8_pkg::xlen_t   mem_addr,
  output legv8_pkg::xlen_t   mem_wdata,
  output logic               mem_read,
  output logic               mem_write
);

  logic                stall;
  legv8_pkg::instr_t   if_instr;
  legv8_pkg::reg_idx_t rd_idx_a;
  legv8_pkg::reg_idx_t rd_idx_b;
  legv8_pkg::xlen_t    rd_data_a;
  legv8_pkg::xlen_t    rd_data_b;

  // ID/EX
  legv8_pkg::alu_ctl_t ex_alu_ctl;
  logic                ex_use_imm;
  logic                ex_mem_read;
  logic                ex_mem_write;
  logic                ex_reg_write;
  legv8_pkg::xlen_t    ex_opnd_a;
  legv8_pkg::xlen_t    ex_opnd_b;
  legv8_pkg::xlen_t    ex_imm;
  legv8_pkg::reg_idx_t ex_src_a;
  legv8_pkg::reg_idx_t ex_src_b;
  legv8_pkg::reg_idx_t ex_dst;

  // EX/MEM and MEM/WB
  logic                m_reg_write;
  legv8_pkg::reg_idx_t m_dst;
  logic                wb_en;
  legv8_pkg::reg_idx_t wb_idx;
  legv8_pkg::xlen_t    wb_data;

  legv8_fetch u_fetch (
    .CLOCK(CLOCK), .arst_n(arst_n), .stall(stall), .instr(instr),
    .pc(pc),
    .if_pc(),                            // No consumer without branches
    .if_instr(if_instr)
  );

  legv8_decode u_decode (
    .CLOCK(CLOCK), .arst_n(arst_n), .if_instr(if_instr),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
    .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b), .stall(stall),
    .ex_alu_ctl(ex_alu_ctl), .ex_use_imm(ex_use_imm),
    .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write), .ex_reg_write(ex_reg_write),
    .ex_opnd_a(ex_opnd_a), .ex_opnd_b(ex_opnd_b), .ex_imm(ex_imm),
    .ex_src_a(ex_src_a), .ex_src_b(ex_src_b), .ex_dst(ex_dst)
  );

  legv8_regfile u_regfile (
    .CLOCK(CLOCK), .arst_n(arst_n), .wb_en(wb_en),
    .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b), .wb_idx(wb_idx), .wb_data(wb_data),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b)
  );

  legv8_execute u_execute (
    .CLOCK(CLOCK), .arst_n(arst_n),
    .ex_alu_ctl(ex_alu_ctl), .ex_use_imm(ex_use_imm),
    .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write), .ex_reg_write(ex_reg_write),
    .ex_opnd_a(ex_opnd_a), .ex_opnd_b(ex_opnd_b), .ex_imm(ex_imm),
    .ex_src_a(ex_src_a), .ex_src_b(ex_src_b), .ex_dst(ex_dst),
    .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_read(mem_read), .mem_write(mem_write),
    .m_reg_write(m_reg_write), .m_dst(m_dst)
  );

  legv8_mem_wb u_mem_wb (
    .CLOCK(CLOCK), .arst_n(arst_n), .mem_read(mem_read), .m_reg_write(m_reg_write),
    .mem_addr(mem_addr), .mem_rdata(mem_rdata), .m_dst(m_dst),
    .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data)
  );

endmodule

//--- verilog/legv8_mem_wb.sv
module legv8_mem_wb (
  input  logic                 CLOCK,
  input  logic                 arst_n,
  input  logic                 mem_read,
  input  logic                 m_reg_write,
  input  legv8_pkg::xlen_t     mem_addr,
  input  legv8_pkg::xlen_t     mem_rdata,
  input  legv8_pkg::reg_idx_t  m_dst,
  output logic                 wb_en,
  output legv8_pkg::reg_idx_t  wb_idx,
  output legv8_pkg::xlen_t     wb_data
);

  logic             wb_load;             // mem2reg
  legv8_pkg::xlen_t wb_alu;
  legv8_pkg::xlen_t wb_mem;

  // MEM/WB control
  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      wb_en   <= 1'b0;
      wb_load <= 1'b0;
    end else begin
      wb_en   <= m_reg_write;
      wb_load <= mem_read;
    end
  end

  // MEM/WB payload
  always_ff @(posedge CLOCK) begin
    wb_alu <= mem_addr;
    wb_mem <= mem_rdata;
    wb_idx <= m_dst;
  end

  assign wb_data = wb_load ? wb_mem : wb_alu;

endmodule

//--- verilog/legv8_execute.sv
`include "legv8_config.svh"

module legv8_execute (
  input  logic                 CLOCK,
  input  logic                 arst_n,
  input  legv8_pkg::alu_ctl_t  ex_alu_ctl,
  input  logic                 ex_use_imm,
  input  logic                 ex_mem_read,
  input  logic                 ex_mem_write,
  input  logic                 ex_reg_write,
  input  legv8_pkg::xlen_t     ex_opnd_a,
  input  legv8_pkg::xlen_t     ex_opnd_b,
  input  legv8_pkg::xlen_t     ex_imm,
  input  legv8_pkg::reg_idx_t  ex_src_a,
  input  legv8_pkg::reg_idx_t  ex_src_b,
  input  legv8_pkg::reg_idx_t  ex_dst,
  input  logic                 wb_en,
  input  legv8_pkg::reg_idx_t  wb_idx,
  input  legv8_pkg::xlen_t     wb_data,
  output legv8_pkg::xlen_t     mem_addr,
  output legv8_pkg::xlen_t     mem_wdata,
  output logic                 mem_read,
  output logic                 mem_write,
  output logic                 m_reg_write,
  output legv8_pkg::reg_idx_t  m_dst
);

  localparam legv8_pkg::reg_idx_t XZR = `LEGV8_ZERO_REG;

  legv8_pkg::fwd_sel_t fwd_a;
  legv8_pkg::fwd_sel_t fwd_b;
  legv8_pkg::xlen_t    opnd_a;
  legv8_pkg::xlen_t    opnd_b;
  legv8_pkg::xlen_t    alu_b;
  legv8_pkg::xlen_t    alu_result;

  // Newest producer wins
  function automatic legv8_pkg::fwd_sel_t fwd_select(input legv8_pkg::reg_idx_t src);
    if (m_reg_write && m_dst != XZR && m_dst == src) return legv8_pkg::FWD_EXMEM;
    if (wb_en && wb_idx != XZR && wb_idx == src) return legv8_pkg::FWD_MEMWB;
    return legv8_pkg::FWD_REG;
  endfunction

  function automatic legv8_pkg::xlen_t fwd_value(input legv8_pkg::fwd_sel_t sel,
                                                 input legv8_pkg::xlen_t reg_val);
    case (sel)
      legv8_pkg::FWD_EXMEM: return mem_addr;   // EX/MEM ALU result
      legv8_pkg::FWD_MEMWB: return wb_data;
      default:              return reg_val;
    endcase
  endfunction

  always_comb begin
    fwd_a  = fwd_select(ex_src_a);
    fwd_b  = fwd_select(ex_src_b);
    opnd_a = fwd_value(fwd_a, ex_opnd_a);
    opnd_b = fwd_value(fwd_b, ex_opnd_b);      // Also the store data
  end

  assign alu_b = ex_use_imm ? ex_imm : opnd_b;

  always_comb begin
    case (ex_alu_ctl)
      legv8_pkg::ALU_ADD: alu_result = opnd_a + alu_b;
      legv8_pkg::ALU_SUB: alu_result = opnd_a - alu_b;
      legv8_pkg::ALU_AND: alu_result = opnd_a & alu_b;
      legv8_pkg::ALU_OR:  alu_result = opnd_a | alu_b;
      legv8_pkg::ALU_XOR: alu_result = opnd_a ^ alu_b;
      default:            alu_result = '0;
    endcase
  end

  // EX/MEM control
  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      mem_read    <= 1'b0;
      mem_write   <= 1'b0;
      m_reg_write <= 1'b0;
    end else begin
      mem_read    <= ex_mem_read;
      mem_write   <= ex_mem_write;
      m_reg_write <= ex_reg_write;
    end
  end

  // EX/MEM payload
  always_ff @(posedge CLOCK) begin
    mem_addr  <= alu_result;
    mem_wdata <= opnd_b;
    m_dst     <= ex_dst;
  end

endmodule

//--- verilog/legv8_regfile.sv
`include "legv8_config.svh"

module legv8_regfile (
  input  logic                 CLOCK,
  input  logic                 arst_n,
  input  logic                 wb_en,
  input  legv8_pkg::reg_idx_t  rd_idx_a,
  input  legv8_pkg::reg_idx_t  rd_idx_b,
  input  legv8_pkg::reg_idx_t  wb_idx,
  input  legv8_pkg::xlen_t     wb_data,
  output legv8_pkg::xlen_t     rd_data_a,
  output legv8_pkg::xlen_t     rd_data_b
);

  localparam legv8_pkg::reg_idx_t XZR = `LEGV8_ZERO_REG;

  legv8_pkg::xlen_t regs [`LEGV8_REG_COUNT];

  // XZR first, then same-cycle writeback, then stored value
  function automatic legv8_pkg::xlen_t read_port(input legv8_pkg::reg_idx_t idx);
    if (idx == XZR) return '0;
    if (wb_en && wb_idx == idx) return wb_data;
    return regs[idx];
  endfunction

  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `LEGV8_REG_COUNT; i++) begin
        regs[i] <= legv8_pkg::xlen_t'(i);   // Xi holds i out of reset
      end
    end else if (wb_en && wb_idx != XZR) begin
      regs[wb_idx] <= wb_data;
    end
  end

  always_comb rd_data_a = read_port(rd_idx_a);
  always_comb rd_data_b = read_port(rd_idx_b);

endmodule

//--- verilog/legv8_decode.sv
`include "legv8_config.svh"

module legv8_decode (
  input  logic                  CLOCK,
  input  logic                  arst_n,
  input  legv8_pkg::instr_t     if_instr,
  input  legv8_pkg::xlen_t      rd_data_a,
  input  legv8_pkg::xlen_t      rd_data_b,
  output legv8_pkg::reg_idx_t   rd_idx_a,
  output legv8_pkg::reg_idx_t   rd_idx_b,
  output logic                  stall,
  output legv8_pkg::alu_ctl_t   ex_alu_ctl,
  output logic                  ex_use_imm,
  output logic                  ex_mem_read,
  output logic                  ex_mem_write,
  output logic                  ex_reg_write,
  output legv8_pkg::xlen_t      ex_opnd_a,
  output legv8_pkg::xlen_t      ex_opnd_b,
  output legv8_pkg::xlen_t      ex_imm,
  output legv8_pkg::reg_idx_t   ex_src_a,
  output legv8_pkg::reg_idx_t   ex_src_b,
  output legv8_pkg::reg_idx_t   ex_dst
);

  localparam legv8_pkg::reg_idx_t XZR = `LEGV8_ZERO_REG;

  legv8_pkg::opcode_t  opc;
  legv8_pkg::alu_ctl_t dec_alu_ctl;
  logic                dec_use_imm;
  logic                dec_mem_read;
  logic                dec_mem_write;
  logic                dec_reg_write;
  legv8_pkg::xlen_t    dec_imm;
  legv8_pkg::xlen_t    i_imm;
  legv8_pkg::xlen_t    d_imm;
  logic                uses_a;
  logic                uses_b;

  assign opc   = if_instr[31:21];
  assign i_imm = {{(`LEGV8_XLEN-12){1'b0}}, if_instr[21:10]};        // ALU_immediate
  assign d_imm = {{(`LEGV8_XLEN-9){if_instr[20]}}, if_instr[20:12]};  // DT_address

  always_comb begin
    dec_alu_ctl   = legv8_pkg::ALU_ADD;
    dec_use_imm   = 1'b0;
    dec_mem_read  = 1'b0;
    dec_mem_write = 1'b0;
    dec_reg_write = 1'b0;
    dec_imm       = i_imm;
    case (opc)
      legv8_pkg::OPC_ADD: dec_reg_write = 1'b1;
      legv8_pkg::OPC_SUB: begin
        dec_reg_write = 1'b1;
        dec_alu_ctl   = legv8_pkg::ALU_SUB;
      end
      legv8_pkg::OPC_AND: begin
        dec_reg_write = 1'b1;
        dec_alu_ctl   = legv8_pkg::ALU_AND;
      end
      legv8_pkg::OPC_ORR: begin
        dec_reg_write = 1'b1;
        dec_alu_ctl   = legv8_pkg::ALU_OR;
      end
      legv8_pkg::OPC_EOR: begin
        dec_reg_write = 1'b1;
        dec_alu_ctl   = legv8_pkg::ALU_XOR;
      end
      legv8_pkg::OPC_LDUR: begin
        dec_reg_write = 1'b1;
        dec_mem_read  = 1'b1;
        dec_use_imm   = 1'b1;
        dec_imm       = d_imm;
      end
      legv8_pkg::OPC_STUR: begin
        dec_mem_write = 1'b1;
        dec_use_imm   = 1'b1;
        dec_imm       = d_imm;
      end
      default: begin
        dec_reg_write = 1'b1;            // Cleared again below if no I-type hit
        dec_use_imm   = 1'b1;
        case (opc[10:1])
          legv8_pkg::OPC_ADDI: dec_alu_ctl = legv8_pkg::ALU_ADD;
          legv8_pkg::OPC_SUBI: dec_alu_ctl = legv8_pkg::ALU_SUB;
          legv8_pkg::OPC_ANDI: dec_alu_ctl = legv8_pkg::ALU_AND;
          legv8_pkg::OPC_ORRI: dec_alu_ctl = legv8_pkg::ALU_OR;
          legv8_pkg::OPC_EORI: dec_alu_ctl = legv8_pkg::ALU_XOR;
          default: begin
            dec_reg_write = 1'b0;        // Unknown encoding
            dec_use_imm   = 1'b0;
          end
        endcase
      end
    endcase
  end

  // Rt replaces Rm as second read port for STUR
  assign rd_idx_a = if_instr[9:5];
  assign rd_idx_b = (opc == legv8_pkg::OPC_STUR) ? if_instr[4:0] : if_instr[20:16];

  // Only real register reads count toward a load-use hazard
  assign uses_a = dec_reg_write | dec_mem_write;
  assign uses_b = uses_a & (~dec_use_imm | dec_mem_write);

  assign stall = ex_mem_read && (ex_dst != XZR) &&
                 ((uses_a && ex_dst == rd_idx_a) || (uses_b && ex_dst == rd_idx_b));

  // ID/EX control, bubble on stall
  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_reg_write <= 1'b0;
    end else begin
      ex_mem_read  <= dec_mem_read & ~stall;
      ex_mem_write <= dec_mem_write & ~stall;
      ex_reg_write <= dec_reg_write & ~stall;
    end
  end

  // ID/EX payload
  always_ff @(posedge CLOCK) begin
    ex_alu_ctl <= dec_alu_ctl;
    ex_use_imm <= dec_use_imm;
    ex_opnd_a  <= rd_data_a;
    ex_opnd_b  <= rd_data_b;
    ex_imm     <= dec_imm;
    ex_src_a   <= rd_idx_a;
    ex_src_b   <= rd_idx_b;
    ex_dst     <= if_instr[4:0];
  end

endmodule

//--- verilog/legv8_fetch.sv
`include "legv8_config.svh"

module legv8_fetch (
  input  logic               CLOCK,
  input  logic               arst_n,
  input  logic               stall,
  input  legv8_pkg::instr_t  instr,
  output legv8_pkg::xlen_t   pc,
  output legv8_pkg::xlen_t   if_pc,
  output legv8_pkg::instr_t  if_instr
);

  localparam legv8_pkg::xlen_t PC_STEP  = `LEGV8_PC_STEP;
  localparam legv8_pkg::xlen_t RESET_PC = `LEGV8_RESET_PC;

  // Program counter
  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      pc <= RESET_PC;
    end else if (!stall) begin
      pc <= pc + PC_STEP;
    end
  end

  // IF/ID register, frozen on load-use
  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      if_pc    <= RESET_PC;
      if_instr <= '0;                    // All-zero decodes as bubble
    end else if (!stall) begin
      if_pc    <= pc;
      if_instr <= instr;
    end
  end

endmodule

//--- verilog/legv8_pkg.sv
`include "legv8_config.svh"

package legv8_pkg;

  typedef logic [`LEGV8_XLEN-1:0] xlen_t;
  typedef logic [`LEGV8_INSTR_W-1:0] instr_t;
  typedef logic [$clog2(`LEGV8_REG_COUNT)-1:0] reg_idx_t;
  typedef logic [10:0] opcode_t;                 // instr[31:21]
  typedef logic [3:0] alu_ctl_t;
  typedef logic [1:0] fwd_sel_t;

  // ALU function codes
  localparam alu_ctl_t ALU_AND = 4'b0000;
  localparam alu_ctl_t ALU_OR  = 4'b0001;
  localparam alu_ctl_t ALU_ADD = 4'b0010;
  localparam alu_ctl_t ALU_SUB = 4'b0110;
  localparam alu_ctl_t ALU_XOR = 4'b1101;

  // Operand source for forwarding
  localparam fwd_sel_t FWD_REG   = 2'b00;
  localparam fwd_sel_t FWD_MEMWB = 2'b01;
  localparam fwd_sel_t FWD_EXMEM = 2'b10;

  // R-type opcodes
  localparam opcode_t OPC_ADD  = 11'b10001011000;
  localparam opcode_t OPC_SUB  = 11'b11001011000;
  localparam opcode_t OPC_AND  = 11'b10001010000;
  localparam opcode_t OPC_ORR  = 11'b10101010000;
  localparam opcode_t OPC_EOR  = 11'b11001010000;

  // D-type opcodes
  localparam opcode_t OPC_LDUR = 11'b11111000010;
  localparam opcode_t OPC_STUR = 11'b11111000000;

  // I-type prefixes, matched against instr[31:22]
  localparam logic [9:0] OPC_ADDI = 10'b1001000100;
  localparam logic [9:0] OPC_SUBI = 10'b1101000100;
  localparam logic [9:0] OPC_ANDI = 10'b1001001000;
  localparam logic [9:0] OPC_ORRI = 10'b1011001000;
  localparam logic [9:0] OPC_EORI = 10'b1101001000;

endpackage

//--- verilog/legv8_config.svh
`ifndef LEGV8_CONFIG_SVH
`define LEGV8_CONFIG_SVH

// Datapath and address width
`define LEGV8_XLEN 64

`define LEGV8_INSTR_W 32

// Architectural registers, XZR included
`define LEGV8_REG_COUNT 32

`define LEGV8_ZERO_REG 31

// Byte step between instructions
`define LEGV8_PC_STEP 4

`define LEGV8_RESET_PC 0

`endif
